// ==== verilog/fetch_cfg.svh ====
// Fetch configuration
// Address widths, line geometry, predictor size and refill timeout

`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// Full PC width and the significant virtual address bits (Sv39)
`define FETCH_PC_WIDTH 64
`define FETCH_VADDR_BITS 39

// 32-bit words per fetch line, 128-bit line
`define FETCH_LINE_WORDS 4

// Predictor entries, indexed by PC[5:2]
`define FETCH_BHT_ENTRIES 16

// Cycles to wait for a refill before raising an access fault
`define FETCH_REFILL_TIMEOUT 12

`endif

// ==== verilog/riscv_pkg.sv ====
// RISC-V ISA types
// Exception causes seen by fetch and the instruction word

package riscv_pkg;

    // Fetch exception causes, encoded as in mcause
    typedef enum logic [3:0] {
        INSTR_ADDR_MISALIGNED = 4'd0,
        INSTR_ACCESS_FAULT    = 4'd1
    } exc_cause_t;

    // Raw 32-bit instruction
    typedef logic [31:0] inst_t;

endpackage

// ==== verilog/fetch_pkg.sv ====
// Fetch pipeline control types
// Next-PC select, fetch FSM states and prediction decision

package fetch_pkg;

    // Next PC source, driven by the control unit
    typedef enum logic [1:0] {
        NEXT_PC_SEL_KEEP_PC    = 2'd0,
        NEXT_PC_SEL_BP_OR_PC_4 = 2'd1,
        NEXT_PC_SEL_JUMP       = 2'd2
    } next_pc_sel_t;

    typedef enum logic [1:0] {
        ST_FETCH     = 2'd0,
        ST_MISS_WAIT = 2'd1,
        ST_DRAIN     = 2'd2
    } fetch_state_t;

    typedef enum logic {
        PRED_NOT_TAKEN = 1'b0,
        PRED_TAKEN     = 1'b1
    } pred_decision_t;

endpackage

// ==== verilog/pc_gen.sv ====
// Program counter generator
// Picks the next fetch PC and checks it for misalignment and canonical form

`include "fetch_cfg.svh"

module pc_gen import fetch_pkg::*; (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  logic [`FETCH_PC_WIDTH-1:0] reset_addr_i,
    input  next_pc_sel_t               next_pc_sel_i,
    input  logic [`FETCH_PC_WIDTH-1:0] pc_jump_i,
    input  logic                       advance_i,
    input  logic                       pred_taken_i,
    input  logic [`FETCH_PC_WIDTH-1:0] pred_addr_i,
    output logic [`FETCH_PC_WIDTH-1:0] pc_o,
    output logic                       ex_misaligned_o,
    output logic                       ex_fault_o
);

    localparam int PC_W = `FETCH_PC_WIDTH;

    logic [PC_W-1:0] pc_q;
    logic [PC_W-1:0] next_pc;

    always_comb begin
        case (next_pc_sel_i)
            NEXT_PC_SEL_BP_OR_PC_4: begin
                // Only move once the current PC has been handed out
                if (!advance_i) begin
                    next_pc = pc_q;
                end else if (pred_taken_i) begin
                    next_pc = pred_addr_i;
                end else begin
                    next_pc = pc_q + PC_W'(4);
                end
            end
            NEXT_PC_SEL_JUMP: next_pc = pc_jump_i;
            default:          next_pc = pc_q;
        endcase
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q <= reset_addr_i;
        end else begin
            pc_q <= next_pc;
        end
    end

    assign pc_o            = pc_q;
    assign ex_misaligned_o = |pc_q[1:0];

    // Upper bits must sign-extend bit 38
    assign ex_fault_o = pc_q[`FETCH_VADDR_BITS-1] ? !(&pc_q[PC_W-1:`FETCH_VADDR_BITS])
                                                   : |pc_q[PC_W-1:`FETCH_VADDR_BITS];

endmodule

// ==== verilog/branch_predictor.sv ====
// Branch predictor
// 2-bit counter history table plus a direct-mapped BTB, trained from execute

`include "fetch_cfg.svh"

module branch_predictor (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  logic [`FETCH_PC_WIDTH-1:0] pc_fetch_i,
    input  logic                       exe_valid_i,
    input  logic [`FETCH_PC_WIDTH-1:0] exe_pc_i,
    input  logic                       exe_taken_i,
    input  logic [`FETCH_PC_WIDTH-1:0] exe_target_i,
    output logic                       pred_taken_o,
    output logic [`FETCH_PC_WIDTH-1:0] pred_addr_o
);

    localparam int PC_W  = `FETCH_PC_WIDTH;
    localparam int IDX_W = $clog2(`FETCH_BHT_ENTRIES);
    localparam int TAG_W = PC_W - IDX_W - 2;

    logic [1:0]       bht_q        [`FETCH_BHT_ENTRIES];
    logic             btb_valid_q  [`FETCH_BHT_ENTRIES];
    logic [TAG_W-1:0] btb_tag_q    [`FETCH_BHT_ENTRIES];
    logic [PC_W-1:0]  btb_target_q [`FETCH_BHT_ENTRIES];

    logic [IDX_W-1:0] fetch_idx;
    logic [TAG_W-1:0] fetch_tag;
    logic [IDX_W-1:0] exe_idx;
    logic [TAG_W-1:0] exe_tag;
    logic [1:0]       exe_ctr;
    logic             btb_hit;

    assign fetch_idx = pc_fetch_i[IDX_W+1:2];
    assign fetch_tag = pc_fetch_i[PC_W-1:IDX_W+2];
    assign exe_idx   = exe_pc_i[IDX_W+1:2];
    assign exe_tag   = exe_pc_i[PC_W-1:IDX_W+2];
    assign exe_ctr   = bht_q[exe_idx];

    // Taken needs a full tag hit and a counter in 10 or 11
    assign btb_hit      = btb_valid_q[fetch_idx] && (btb_tag_q[fetch_idx] == fetch_tag);
    assign pred_taken_o = btb_hit && bht_q[fetch_idx][1];
    assign pred_addr_o  = btb_target_q[fetch_idx];

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < `FETCH_BHT_ENTRIES; i++) begin
                bht_q[i]       <= 2'b01;
                btb_valid_q[i] <= 1'b0;
            end
        end else if (exe_valid_i) begin
            if (exe_taken_i) begin
                btb_valid_q[exe_idx] <= 1'b1;
                if (exe_ctr != 2'b11) begin
                    bht_q[exe_idx] <= exe_ctr + 2'd1;
                end
            end else if (exe_ctr != 2'b00) begin
                bht_q[exe_idx] <= exe_ctr - 2'd1;
            end
        end
    end

    // BTB payload, qualified by the valid bits above
    always_ff @(posedge clk_i) begin
        if (exe_valid_i && exe_taken_i) begin
            btb_tag_q[exe_idx]    <= exe_tag;
            btb_target_q[exe_idx] <= exe_target_i;
        end
    end

endmodule

// ==== verilog/fetch_ctrl.sv ====
// Fetch control FSM
// Sequences line refills, drains refills made stale by a jump, gates fetch output

`include "fetch_cfg.svh"

module fetch_ctrl import fetch_pkg::*; (
    input  logic clk_i,
    input  logic rstn_i,
    input  logic stall_i,
    input  logic jump_i,
    input  logic has_ex_i,
    input  logic hit_i,
    input  logic mem_valid_i,
    input  logic timeout_i,
    output logic fetch_valid_o,
    output logic advance_o,
    output logic mem_req_o,
    output logic line_wr_o,
    output logic timer_run_o,
    output logic timeout_fault_o
);

    fetch_state_t state_q;
    fetch_state_t state_d;
    logic         started_q;
    logic         fault_q;
    logic         can_fetch;

    // Idle for the first cycle after reset
    assign can_fetch = started_q && (state_q == ST_FETCH) && !stall_i;

    assign fetch_valid_o   = can_fetch && (has_ex_i || hit_i || fault_q);
    assign advance_o       = fetch_valid_o;
    // A jump this cycle makes the miss stale, so skip the request
    assign mem_req_o       = can_fetch && !has_ex_i && !hit_i && !fault_q && !jump_i;
    assign line_wr_o       = (state_q == ST_MISS_WAIT) && mem_valid_i;
    assign timer_run_o     = (state_q != ST_FETCH);
    assign timeout_fault_o = fault_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_FETCH: begin
                if (mem_req_o) begin
                    state_d = ST_MISS_WAIT;
                end
            end
            ST_MISS_WAIT: begin
                // A response in the jump cycle still belongs to the current PC
                if (mem_valid_i || timeout_i) begin
                    state_d = ST_FETCH;
                end else if (jump_i) begin
                    state_d = ST_DRAIN;
                end
            end
            ST_DRAIN: begin
                if (mem_valid_i || timeout_i) begin
                    state_d = ST_FETCH;
                end
            end
            default: state_d = ST_FETCH;
        endcase
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            state_q   <= ST_FETCH;
            started_q <= 1'b0;
            fault_q   <= 1'b0;
        end else begin
            state_q   <= state_d;
            started_q <= 1'b1;
            if (state_q == ST_MISS_WAIT && timeout_i && !mem_valid_i && !jump_i) begin
                fault_q <= 1'b1;
            end else if (fetch_valid_o || jump_i) begin
                fault_q <= 1'b0;
            end
        end
    end

endmodule

// ==== verilog/refill_timer.sv ====
// Refill timer
// Counts cycles spent waiting on memory and flags a timeout

`include "fetch_cfg.svh"

module refill_timer (
    input  logic clk_i,
    input  logic rstn_i,
    input  logic run_i,
    output logic timeout_o
);

    localparam int CNT_W = $clog2(`FETCH_REFILL_TIMEOUT + 1);

    logic [CNT_W-1:0] count_q;

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            count_q <= '0;
        end else if (!run_i) begin
            count_q <= '0;
        end else if (!timeout_o) begin
            count_q <= count_q + CNT_W'(1);
        end
    end

    assign timeout_o = run_i && (count_q == CNT_W'(`FETCH_REFILL_TIMEOUT));

endmodule

// ==== verilog/line_buffer.sv ====
// Fetch line buffer
// Holds one instruction line with its tag and valid bit, selects the word for the PC

`include "fetch_cfg.svh"

module line_buffer import riscv_pkg::*; (
    input  logic                              clk_i,
    input  logic                              rstn_i,
    input  logic [`FETCH_PC_WIDTH-1:0]        pc_i,
    input  logic                              wr_i,
    input  logic [`FETCH_LINE_WORDS*32-1:0]   wr_line_i,
    input  logic                              invalidate_i,
    output logic                              hit_o,
    output inst_t                             inst_o
);

    localparam int OFF_W = $clog2(`FETCH_LINE_WORDS * 4);
    localparam int TAG_W = `FETCH_PC_WIDTH - OFF_W;
    localparam int SEL_W = $clog2(`FETCH_LINE_WORDS);

    inst_t            line_q [`FETCH_LINE_WORDS];
    logic [TAG_W-1:0] tag_q;
    logic             valid_q;

    // Refill wins over invalidate in the same cycle
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= 1'b0;
        end else if (wr_i) begin
            valid_q <= 1'b1;
        end else if (invalidate_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_i) begin
            tag_q <= pc_i[`FETCH_PC_WIDTH-1:OFF_W];
            for (int w = 0; w < `FETCH_LINE_WORDS; w++) begin
                line_q[w] <= wr_line_i[w*32 +: 32];
            end
        end
    end

    assign hit_o  = valid_q && (tag_q == pc_i[`FETCH_PC_WIDTH-1:OFF_W]);
    assign inst_o = line_q[pc_i[SEL_W+1:2]];

endmodule

// ==== verilog/fetch_top.sv ====
// Instruction fetch, first stage
// PC generation, branch prediction and a refilled line buffer

`include "fetch_cfg.svh"

module fetch_top import riscv_pkg::*; import fetch_pkg::*; (
    input  logic                            clk_i,
    input  logic                            rstn_i,
    input  logic [`FETCH_PC_WIDTH-1:0]      reset_addr_i,
    input  logic                            stall_i,
    input  next_pc_sel_t                    next_pc_sel_i,
    input  logic [`FETCH_PC_WIDTH-1:0]      pc_jump_i,
    input  logic                            invalidate_i,
    input  logic                            exe_valid_i,
    input  logic [`FETCH_PC_WIDTH-1:0]      exe_pc_i,
    input  logic                            exe_taken_i,
    input  logic [`FETCH_PC_WIDTH-1:0]      exe_target_i,
    output logic                            mem_req_o,
    output logic [`FETCH_PC_WIDTH-1:0]      mem_addr_o,
    input  logic                            mem_valid_i,
    input  logic [`FETCH_LINE_WORDS*32-1:0] mem_line_i,
    output logic                            fetch_valid_o,
    output logic [`FETCH_PC_WIDTH-1:0]      fetch_pc_o,
    output inst_t                           fetch_inst_o,
    output logic                            fetch_ex_valid_o,
    output exc_cause_t                      fetch_ex_cause_o,
    output pred_decision_t                  fetch_pred_taken_o,
    output logic [`FETCH_PC_WIDTH-1:0]      fetch_pred_addr_o
);

    localparam int OFF_W = $clog2(`FETCH_LINE_WORDS * 4);

    logic [`FETCH_PC_WIDTH-1:0] pc;
    logic [`FETCH_PC_WIDTH-1:0] pred_addr;
    logic ex_misaligned;
    logic ex_fault;
    logic timeout_fault;
    logic pred_taken;
    logic hit;
    logic advance;
    logic line_wr;
    logic timer_run;
    logic timeout;

    pc_gen u_pc_gen (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .reset_addr_i   (reset_addr_i),
        .next_pc_sel_i  (next_pc_sel_i),
        .pc_jump_i      (pc_jump_i),
        .advance_i      (advance),
        .pred_taken_i   (pred_taken),
        .pred_addr_i    (pred_addr),
        .pc_o           (pc),
        .ex_misaligned_o(ex_misaligned),
        .ex_fault_o     (ex_fault)
    );

    branch_predictor u_branch_predictor (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .pc_fetch_i  (pc),
        .exe_valid_i (exe_valid_i),
        .exe_pc_i    (exe_pc_i),
        .exe_taken_i (exe_taken_i),
        .exe_target_i(exe_target_i),
        .pred_taken_o(pred_taken),
        .pred_addr_o (pred_addr)
    );

    fetch_ctrl u_fetch_ctrl (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .stall_i        (stall_i),
        .jump_i         (next_pc_sel_i == NEXT_PC_SEL_JUMP),
        .has_ex_i       (ex_misaligned || ex_fault),
        .hit_i          (hit),
        .mem_valid_i    (mem_valid_i),
        .timeout_i      (timeout),
        .fetch_valid_o  (fetch_valid_o),
        .advance_o      (advance),
        .mem_req_o      (mem_req_o),
        .line_wr_o      (line_wr),
        .timer_run_o    (timer_run),
        .timeout_fault_o(timeout_fault)
    );

    refill_timer u_refill_timer (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .run_i    (timer_run),
        .timeout_o(timeout)
    );

    line_buffer u_line_buffer (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .pc_i        (pc),
        .wr_i        (line_wr),
        .wr_line_i   (mem_line_i),
        .invalidate_i(invalidate_i),
        .hit_o       (hit),
        .inst_o      (fetch_inst_o)
    );

    // Line-aligned request address
    assign mem_addr_o = {pc[`FETCH_PC_WIDTH-1:OFF_W], {OFF_W{1'b0}}};
    assign fetch_pc_o = pc;

    // Misaligned beats both kinds of access fault
    assign fetch_ex_valid_o = ex_misaligned || ex_fault || timeout_fault;
    assign fetch_ex_cause_o = ex_misaligned ? INSTR_ADDR_MISALIGNED : INSTR_ACCESS_FAULT;

    assign fetch_pred_taken_o = pred_taken ? PRED_TAKEN : PRED_NOT_TAKEN;
    assign fetch_pred_addr_o  = pred_addr;

endmodule

// ==== testbench/tb_fetch_top.sv ====
// Fetch stage testbench
// Random stimulus checked every cycle against a model of the PC, line, FSM and predictor

`include "fetch_cfg.svh"

module tb_fetch_top import riscv_pkg::*; import fetch_pkg::*; ();

    localparam int          NUM_CYCLES = 2000;
    localparam int          MAX_CYCLES = 2 * NUM_CYCLES;
    localparam logic [63:0] RESET_ADDR = 64'h0000_0000_8000_0000;
    // Memory never answers a line with this address bit set
    localparam int          DEAD_BIT   = 12;

    logic                               clk_i;
    logic                               rstn_i;
    logic [`FETCH_PC_WIDTH-1:0]         reset_addr_i;
    logic                               stall_i;
    next_pc_sel_t                       next_pc_sel_i;
    logic [`FETCH_PC_WIDTH-1:0]         pc_jump_i;
    logic                               invalidate_i;
    logic                               exe_valid_i;
    logic [`FETCH_PC_WIDTH-1:0]         exe_pc_i;
    logic                               exe_taken_i;
    logic [`FETCH_PC_WIDTH-1:0]         exe_target_i;
    logic                               mem_req_o;
    logic [`FETCH_PC_WIDTH-1:0]         mem_addr_o;
    logic                               mem_valid_i;
    logic [`FETCH_LINE_WORDS*32-1:0]    mem_line_i;
    logic                               fetch_valid_o;
    logic [`FETCH_PC_WIDTH-1:0]         fetch_pc_o;
    inst_t                              fetch_inst_o;
    logic                               fetch_ex_valid_o;
    exc_cause_t                         fetch_ex_cause_o;
    pred_decision_t                     fetch_pred_taken_o;
    logic [`FETCH_PC_WIDTH-1:0]         fetch_pred_addr_o;

    integer      seed = 6645;
    logic [31:0] image [1024];

    // Reference model state
    logic [63:0]  m_pc;
    fetch_state_t m_state;
    logic         m_started;
    logic         m_fault;
    logic         m_valid;
    logic [59:0]  m_tag;
    int           m_count;
    logic [1:0]   m_bht        [16];
    logic         m_btb_valid  [16];
    logic [57:0]  m_btb_tag    [16];
    logic [63:0]  m_btb_target [16];

    // Memory model
    logic        mem_pending;
    int          mem_delay;
    logic [63:0] mem_req_addr;

    int cycle_count;
    int stim_cycle;
    int cov_pred;
    int cov_misaligned;
    int cov_noncanon;
    int cov_both;
    int cov_timeout;
    int cov_drain;
    int cov_hit;

    fetch_top dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk_i);
            cycle_count++;
            if (cycle_count >= MAX_CYCLES) begin
                $display("Timeout: the run went past %0d cycles", MAX_CYCLES);
                $display("*** TEST FAILED ***");
                $fatal(1, "timeout");
            end
        end
    end

    // Image word mixed with the whole address
    function automatic logic [31:0] word_at(input logic [63:0] addr);
        return image[addr[11:2]] ^ addr[31:0] ^ addr[63:32];
    endfunction

    function automatic logic [127:0] line_data(input logic [63:0] line_addr);
        logic [127:0] line;
        for (int w = 0; w < `FETCH_LINE_WORDS; w++) begin
            line[w*32 +: 32] = word_at(line_addr + 64'(w * 4));
        end
        return line;
    endfunction

    // Bits 63 to 39 must repeat bit 38
    function automatic logic non_canonical(input logic [63:0] addr);
        return addr[63:`FETCH_VADDR_BITS-1] != {(65-`FETCH_VADDR_BITS){addr[`FETCH_VADDR_BITS-1]}};
    endfunction

    task automatic compare_value(input string name, input logic [63:0] actual,
                                 input logic [63:0] expected);
        if (actual !== expected) begin
            $display("FAILED at time %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("*** TEST FAILED ***");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic require_seen(input string what, input int count);
        if (count == 0) begin
            $display("The random stimulus never produced %s", what);
            $display("*** TEST FAILED ***");
            $fatal(1, "scenario not reached");
        end
    endtask

    // Called right after a rising edge
    task automatic drive_stimulus();
        logic [31:0] r;
        logic [63:0] t;
        r = $random(seed);
        stall_i      <= (r[3:0] == 4'd0);
        invalidate_i <= (r[8:4] == 5'd0);
        case (r[12:9])
            4'd0:    next_pc_sel_i <= NEXT_PC_SEL_JUMP;
            4'd1:    next_pc_sel_i <= NEXT_PC_SEL_KEEP_PC;
            default: next_pc_sel_i <= NEXT_PC_SEL_BP_OR_PC_4;
        endcase
        // Quiet start so the first fetch comes from the reset address
        if (stim_cycle < 4) begin
            stall_i       <= 1'b0;
            next_pc_sel_i <= NEXT_PC_SEL_BP_OR_PC_4;
        end
        r = $random(seed);
        t = 64'h0000_0000_8000_0000 | {56'd0, r[5:0], 2'b00};
        if (r[9:8] == 2'd0) begin
            t[DEAD_BIT] = 1'b1;
        end
        if (r[12:11] == 2'd0) begin
            t[1:0] = (r[14:13] == 2'd0) ? 2'b10 : r[14:13];
        end
        if (r[16:15] == 2'd0) begin
            t[45] = 1'b1;
        end
        pc_jump_i <= t;
        r = $random(seed);
        exe_valid_i  <= (r[1:0] == 2'd0);
        exe_taken_i  <= (r[3:2] != 2'd0);
        exe_pc_i     <= 64'h0000_0000_8000_0000 | {58'd0, r[7:4], 2'b00};
        exe_target_i <= 64'h0000_0000_8000_0000 | {56'd0, r[13:8], 2'b00};
        mem_valid_i <= 1'b0;
        if (mem_pending) begin
            if (mem_delay == 1) begin
                mem_valid_i <= 1'b1;
                mem_line_i  <= line_data(mem_req_addr);
                mem_pending = 1'b0;
            end else begin
                mem_delay = mem_delay - 1;
            end
        end
        stim_cycle++;
    endtask

    // Called at the falling edge: check outputs, then advance the model
    task automatic step_model();
        logic        mis;
        logic        nc;
        logic        has_ex;
        logic        hit;
        logic        jump;
        logic        can;
        logic        exp_valid;
        logic        exp_req;
        logic        pred;
        logic        timeout;
        logic [3:0]  idx;
        logic [3:0]  eidx;
        logic [31:0] r;
        mis       = |m_pc[1:0];
        nc        = non_canonical(m_pc);
        has_ex    = mis || nc;
        hit       = m_valid && (m_tag == m_pc[63:4]);
        jump      = (next_pc_sel_i == NEXT_PC_SEL_JUMP);
        can       = m_started && (m_state == ST_FETCH) && !stall_i;
        exp_valid = can && (has_ex || hit || m_fault);
        exp_req   = can && !has_ex && !hit && !m_fault && !jump;
        idx       = m_pc[5:2];
        pred      = m_btb_valid[idx] && (m_btb_tag[idx] == m_pc[63:6]) && m_bht[idx][1];
        timeout   = (m_state != ST_FETCH) && (m_count == `FETCH_REFILL_TIMEOUT);

        compare_value("fetch_pc_o", fetch_pc_o, m_pc);
        compare_value("fetch_valid_o", 64'(fetch_valid_o), 64'(exp_valid));
        compare_value("mem_req_o", 64'(mem_req_o), 64'(exp_req));
        if (exp_req) begin
            compare_value("mem_addr_o", mem_addr_o, {m_pc[63:4], 4'h0});
        end
        if (exp_valid) begin
            compare_value("fetch_ex_valid_o", 64'(fetch_ex_valid_o), 64'(has_ex || m_fault));
            compare_value("fetch_pred_taken_o", 64'(fetch_pred_taken_o),
                          64'(pred ? PRED_TAKEN : PRED_NOT_TAKEN));
            if (pred) begin
                compare_value("fetch_pred_addr_o", fetch_pred_addr_o, m_btb_target[idx]);
            end
            if (mis) begin
                compare_value("fetch_ex_cause_o", 64'(fetch_ex_cause_o),
                              64'(INSTR_ADDR_MISALIGNED));
            end else if (nc || m_fault) begin
                compare_value("fetch_ex_cause_o", 64'(fetch_ex_cause_o), 64'(INSTR_ACCESS_FAULT));
            end else begin
                compare_value("fetch_inst_o", 64'(fetch_inst_o), 64'(word_at(m_pc)));
            end
        end

        if (exp_valid && pred) cov_pred++;
        if (exp_valid && mis && !nc) cov_misaligned++;
        if (exp_valid && nc && !mis) cov_noncanon++;
        if (exp_valid && mis && nc) cov_both++;
        if (exp_valid && m_fault && !has_ex) cov_timeout++;
        if (exp_valid && hit && !has_ex) cov_hit++;
        if (m_state == ST_MISS_WAIT && jump && !mem_valid_i && !timeout) cov_drain++;

        // Memory takes the request unless the line is in the dead region
        if (exp_req && !mem_addr_o[DEAD_BIT]) begin
            r            = $random(seed);
            mem_pending  = 1'b1;
            mem_delay    = 1 + int'(r[2:0]);
            mem_req_addr = mem_addr_o;
        end

        // Fault pulse only when the timeout ends a live refill
        if (m_state == ST_MISS_WAIT && timeout && !mem_valid_i && !jump) begin
            m_fault = 1'b1;
        end else if (exp_valid || jump) begin
            m_fault = 1'b0;
        end
        if (m_state == ST_FETCH) begin
            m_count = 0;
        end else if (m_count != `FETCH_REFILL_TIMEOUT) begin
            m_count++;
        end
        if (m_state == ST_MISS_WAIT && mem_valid_i) begin
            m_valid = 1'b1;
            m_tag   = m_pc[63:4];
        end else if (invalidate_i) begin
            m_valid = 1'b0;
        end
        case (m_state)
            ST_FETCH: begin
                if (exp_req) begin
                    m_state = ST_MISS_WAIT;
                end
            end
            ST_MISS_WAIT: begin
                if (mem_valid_i || timeout) begin
                    m_state = ST_FETCH;
                end else if (jump) begin
                    m_state = ST_DRAIN;
                end
            end
            default: begin
                if (mem_valid_i || timeout) begin
                    m_state = ST_FETCH;
                end
            end
        endcase

        if (jump) begin
            m_pc = pc_jump_i;
        end else if (next_pc_sel_i == NEXT_PC_SEL_BP_OR_PC_4 && exp_valid) begin
            m_pc = pred ? m_btb_target[idx] : m_pc + 64'd4;
        end

        if (exe_valid_i) begin
            eidx = exe_pc_i[5:2];
            if (exe_taken_i) begin
                m_btb_valid[eidx]  = 1'b1;
                m_btb_tag[eidx]    = exe_pc_i[63:6];
                m_btb_target[eidx] = exe_target_i;
                if (m_bht[eidx] != 2'b11) begin
                    m_bht[eidx] = m_bht[eidx] + 2'd1;
                end
            end else if (m_bht[eidx] != 2'b00) begin
                m_bht[eidx] = m_bht[eidx] - 2'd1;
            end
        end
        m_started = 1'b1;
    endtask

    initial begin
        rstn_i        = 1'b0;
        reset_addr_i  = RESET_ADDR;
        stall_i       = 1'b0;
        next_pc_sel_i = NEXT_PC_SEL_BP_OR_PC_4;
        pc_jump_i     = '0;
        invalidate_i  = 1'b0;
        exe_valid_i   = 1'b0;
        exe_pc_i      = '0;
        exe_taken_i   = 1'b0;
        exe_target_i  = '0;
        mem_valid_i   = 1'b0;
        mem_line_i    = '0;
        for (int i = 0; i < 1024; i++) begin
            image[i] = $random(seed);
        end
        m_pc      = RESET_ADDR;
        m_state   = ST_FETCH;
        m_started = 1'b0;
        m_fault   = 1'b0;
        m_valid   = 1'b0;
        m_tag     = '0;
        m_count   = 0;
        for (int i = 0; i < 16; i++) begin
            m_bht[i]       = 2'b01;
            m_btb_valid[i] = 1'b0;
        end
        mem_pending    = 1'b0;
        mem_delay      = 0;
        stim_cycle     = 0;
        cov_pred       = 0;
        cov_misaligned = 0;
        cov_noncanon   = 0;
        cov_both       = 0;
        cov_timeout    = 0;
        cov_drain      = 0;
        cov_hit        = 0;

        // Two cycles in reset with quiet outputs
        repeat (2) begin
            @(negedge clk_i);
            compare_value("fetch_pc_o", fetch_pc_o, RESET_ADDR);
            compare_value("mem_req_o", 64'(mem_req_o), 64'd0);
            compare_value("fetch_valid_o", 64'(fetch_valid_o), 64'd0);
        end
        @(posedge clk_i);
        rstn_i <= 1'b1;
        drive_stimulus();

        repeat (NUM_CYCLES) begin
            @(negedge clk_i);
            step_model();
            @(posedge clk_i);
            drive_stimulus();
        end

        require_seen("a taken prediction", cov_pred);
        require_seen("a misaligned fetch", cov_misaligned);
        require_seen("a non-canonical fetch", cov_noncanon);
        require_seen("a misaligned non-canonical fetch", cov_both);
        require_seen("a refill timeout fault", cov_timeout);
        require_seen("a jump during a refill", cov_drain);
        require_seen("a line buffer hit", cov_hit);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+verilog
verilog/riscv_pkg.sv
verilog/fetch_pkg.sv
verilog/pc_gen.sv
verilog/branch_predictor.sv
verilog/fetch_ctrl.sv
verilog/refill_timer.sv
verilog/line_buffer.sv
verilog/fetch_top.sv
testbench/tb_fetch_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile the fetch stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary -f build.f --top-module tb_fetch_top --Mdir obj_dir -o tb_fetch_top
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_fetch_top > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q -F "*** TEST FAILED ***" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
echo "Simulation passed"
exit 0
